// ==== acc_dispatcher/acc_dispatcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module acc_dispatcher import core_if_pkg::*; import acc_if_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  // Consistency mode from the CSR file
  input  logic            acc_cons_en_i,
  // Issue stage
  input  fu_data_t        acc_data_i,
  input  logic            acc_valid_i,
  output logic            acc_ready_o,
  // Commit stage
  input  logic            acc_commit_i,
  input  trans_id_t       acc_commit_trans_id_i,
  // Load/store unit
  input  logic            acc_no_st_pending_i,
  output logic            acc_ld_disp_o,
  output logic            acc_st_disp_o,
  output logic            acc_flush_undisp_o,
  // Writeback
  output trans_id_t       acc_trans_id_o,
  output logic [XLEN-1:0] acc_result_o,
  output logic            acc_valid_o,
  output exception_t      acc_exception_o,
  // Accelerator port
  output acc_req_t        acc_req_o,
  output logic            acc_req_valid_o,
  input  logic            acc_req_ready_i,
  input  acc_resp_t       acc_resp_i,
  input  logic            acc_resp_valid_i
);

  localparam int unsigned NUM_IDS = 2 ** TRANS_ID_BITS;

  fu_data_t           busy_data;
  logic               busy_valid;
  logic               busy_ready;
  logic               ft_ready;
  fu_data_t           head_data;
  logic               head_valid;
  logic               head_ready;
  logic [NUM_IDS-1:0] commit_match_q;
  logic [NUM_IDS-1:0] commit_match_d;
  logic               head_match;
  logic               req_fire;

  assign acc_flush_undisp_o = flush_i;

  // Catches an issue that the head register cannot take
  fall_through_reg i_busy_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clr_i   (flush_i),
    .valid_i (acc_valid_i),
    .data_i  (acc_data_i),
    .ready_o (ft_ready),
    .valid_o (busy_valid),
    .data_o  (busy_data),
    .ready_i (busy_ready)
  );

  // Head of the issue path, waits here for commit
  stream_reg i_head_reg (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .clr_i   (flush_i),
    .valid_i (busy_valid),
    .data_i  (busy_data),
    .ready_o (busy_ready),
    .valid_o (head_valid),
    .data_o  (head_data),
    .ready_i (head_ready)
  );

  // Issue sees the ready of the first register in the chain
  // It drops only once both registers hold an operation
  assign acc_ready_o = ft_ready;

  // Head is committed if its flag is set or its commit arrives now
  assign head_match = commit_match_q[head_data.trans_id]
                    | (acc_commit_i && acc_commit_trans_id_i == head_data.trans_id);

  // Speculative operations stay put
  assign acc_req_valid_o = head_valid & head_match;
  assign head_ready      = acc_req_ready_i & head_match;
  assign req_fire        = acc_req_valid_o & acc_req_ready_i;

  // Commit flags kept per id, so early commits are not lost
  always_comb begin
    commit_match_d = commit_match_q;
    if (acc_commit_i) begin
      commit_match_d[acc_commit_trans_id_i] = 1'b1;
    end
    // Consumed once the accelerator takes the request
    if (req_fire) begin
      commit_match_d[head_data.trans_id] = 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || flush_i) begin
      commit_match_q <= '0;
    end else begin
      commit_match_q <= commit_match_d;
    end
  end

  // Instruction word rides in the immediate field
  assign acc_req_o = '{
    insn:          acc_insn_u'(head_data.imm),
    rs1:           head_data.operand_a,
    rs2:           head_data.operand_b,
    trans_id:      head_data.trans_id,
    store_pending: acc_cons_en_i & ~acc_no_st_pending_i
  };

  // Response side is always ready
  assign acc_valid_o     = acc_resp_valid_i;
  assign acc_trans_id_o  = acc_resp_i.trans_id;
  assign acc_result_o    = acc_resp_i.result;
  assign acc_exception_o = '{
    cause: CAUSE_ILLEGAL_INSTR,
    tval:  '0,
    valid: acc_resp_i.error
  };

  // Tell issue about memory operators at the head
  assign acc_ld_disp_o = acc_req_ready_i & head_valid & (head_data.operator == ACCEL_OP_LOAD);
  assign acc_st_disp_o = acc_req_ready_i & head_valid & (head_data.operator == ACCEL_OP_STORE);

endmodule

`default_nettype wire

// ==== accel/accel_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module accel_alu import core_if_pkg::*; import acc_if_pkg::*; #(
  parameter int unsigned ACC_LATENCY = 3
) (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  acc_req_t  req_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  output acc_resp_t resp_o,
  output logic      resp_valid_o
);

  acc_insn_u       insn;
  logic            accept;
  logic [XLEN-1:0] imm_sext;
  acc_resp_t       resp_d;
  logic            valid_q [ACC_LATENCY];
  acc_resp_t       resp_q  [ACC_LATENCY];

  // Hold off while a core store is outstanding
  assign req_ready_o = ~req_i.store_pending;
  assign accept      = req_valid_i & req_ready_o;

  assign insn     = req_i.insn;
  // Only meaningful for the register-immediate form
  assign imm_sext = {{(XLEN-12){insn.i.imm12[11]}}, insn.i.imm12};

  // Decode and execute in the accept cycle
  always_comb begin
    resp_d.trans_id = req_i.trans_id;
    resp_d.result   = '0;
    resp_d.error    = 1'b0;
    if (insn.r.opcode != ACC_OPCODE) begin
      resp_d.error = 1'b1;
    end else begin
      case (insn.r.funct3)
        F_ADD: begin
          resp_d.result = req_i.rs1 + req_i.rs2;
        end
        F_SUB: begin
          resp_d.result = req_i.rs1 - req_i.rs2;
        end
        F_XOR: begin
          resp_d.result = req_i.rs1 ^ req_i.rs2;
        end
        F_ADDI: begin
          resp_d.result = req_i.rs1 + imm_sext;
        end
        default: begin
          // Undefined funct3
          resp_d.error = 1'b1;
        end
      endcase
    end
  end

  // Valid bits shift each cycle, so one request per cycle can enter
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < ACC_LATENCY; i++) begin
        valid_q[i] <= 1'b0;
      end
    end else begin
      valid_q[0] <= accept;
      for (int i = 1; i < ACC_LATENCY; i++) begin
        valid_q[i] <= valid_q[i-1];
      end
    end
  end

  // Payload stages, no reset
  always_ff @(posedge clk_i) begin
    if (accept) begin
      resp_q[0] <= resp_d;
    end
    for (int i = 1; i < ACC_LATENCY; i++) begin
      resp_q[i] <= resp_q[i-1];
    end
  end

  // Last stage drives a one-cycle strobe
  assign resp_valid_o = valid_q[ACC_LATENCY-1];
  assign resp_o       = resp_q[ACC_LATENCY-1];

endmodule

`default_nettype wire

// ==== common/acc_if_pkg.sv ====
`default_nettype none

// Types of the request/response port toward the accelerator
package acc_if_pkg;

  import core_if_pkg::*;

  // Custom-0 major opcode
  localparam logic [6:0] ACC_OPCODE = 7'b0001011;

  // Register-register layout of a custom instruction
  typedef struct packed {
    logic [6:0]  funct7;
    logic [4:0]  rs2;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } acc_insn_r_t;

  // Register-immediate layout of a custom instruction
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } acc_insn_i_t;

  // Same 32-bit word, seen either way
  typedef union packed {
    acc_insn_r_t r;
    acc_insn_i_t i;
  } acc_insn_u;

  // funct3 selects the operation
  typedef enum logic [2:0] {
    F_ADD  = 3'd0,
    F_SUB  = 3'd1,
    F_XOR  = 3'd2,
    F_ADDI = 3'd3
  } acc_funct_e;

  typedef struct packed {
    acc_insn_u         insn;
    logic [XLEN-1:0]   rs1;
    logic [XLEN-1:0]   rs2;
    trans_id_t         trans_id;
    // Set while the accelerator must hold off for a core store
    logic              store_pending;
  } acc_req_t;

  typedef struct packed {
    logic [XLEN-1:0]   result;
    trans_id_t         trans_id;
    logic              error;
  } acc_resp_t;

endpackage

`default_nettype wire

// ==== common/core_if_pkg.sv ====
`default_nettype none

// Types shared with the core side of the accelerator port
package core_if_pkg;

  // Data word width of the core
  localparam int unsigned XLEN = 32;

  // Scoreboard transaction id width
  localparam int unsigned TRANS_ID_BITS = 3;

  typedef logic [TRANS_ID_BITS-1:0] trans_id_t;

  // Operator classes that the issue stage hands to the accelerator port
  typedef enum logic [1:0] {
    ACCEL_OP       = 2'd0,
    ACCEL_OP_LOAD  = 2'd1,
    ACCEL_OP_STORE = 2'd2
  } fu_op_e;

  // One issued operation
  // The raw instruction word travels in imm
  typedef struct packed {
    fu_op_e            operator;
    logic [XLEN-1:0]   operand_a;
    logic [XLEN-1:0]   operand_b;
    logic [31:0]       imm;
    trans_id_t         trans_id;
  } fu_data_t;

  // Exception record returned with a result
  typedef struct packed {
    logic [3:0]        cause;
    logic [XLEN-1:0]   tval;
    logic              valid;
  } exception_t;

  // Illegal instruction cause code
  localparam logic [3:0] CAUSE_ILLEGAL_INSTR = 4'd2;

endpackage

`default_nettype wire

// ==== design/acc_subsys_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module acc_subsys_top import core_if_pkg::*; import acc_if_pkg::*; #(
  // Accelerator pipeline depth, at least 1
  parameter int unsigned ACC_LATENCY = 3
) (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            flush_i,
  input  logic            acc_cons_en_i,
  input  fu_data_t        acc_data_i,
  input  logic            acc_valid_i,
  output logic            acc_ready_o,
  input  logic            acc_commit_i,
  input  trans_id_t       acc_commit_trans_id_i,
  input  logic            acc_no_st_pending_i,
  output logic            acc_ld_disp_o,
  output logic            acc_st_disp_o,
  output logic            acc_flush_undisp_o,
  output trans_id_t       acc_trans_id_o,
  output logic [XLEN-1:0] acc_result_o,
  output logic            acc_valid_o,
  output exception_t      acc_exception_o
);

  // Dispatcher to accelerator
  acc_req_t  acc_req;
  logic      acc_req_valid;
  logic      acc_req_ready;
  // Accelerator back to dispatcher
  acc_resp_t acc_resp;
  logic      acc_resp_valid;

  acc_dispatcher i_acc_dispatcher (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .flush_i               (flush_i),
    .acc_cons_en_i         (acc_cons_en_i),
    .acc_data_i            (acc_data_i),
    .acc_valid_i           (acc_valid_i),
    .acc_ready_o           (acc_ready_o),
    .acc_commit_i          (acc_commit_i),
    .acc_commit_trans_id_i (acc_commit_trans_id_i),
    .acc_no_st_pending_i   (acc_no_st_pending_i),
    .acc_ld_disp_o         (acc_ld_disp_o),
    .acc_st_disp_o         (acc_st_disp_o),
    .acc_flush_undisp_o    (acc_flush_undisp_o),
    .acc_trans_id_o        (acc_trans_id_o),
    .acc_result_o          (acc_result_o),
    .acc_valid_o           (acc_valid_o),
    .acc_exception_o       (acc_exception_o),
    .acc_req_o             (acc_req),
    .acc_req_valid_o       (acc_req_valid),
    .acc_req_ready_i       (acc_req_ready),
    .acc_resp_i            (acc_resp),
    .acc_resp_valid_i      (acc_resp_valid)
  );

  accel_alu #(
    .ACC_LATENCY (ACC_LATENCY)
  ) i_accel_alu (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (acc_req),
    .req_valid_i  (acc_req_valid),
    .req_ready_o  (acc_req_ready),
    .resp_o       (acc_resp),
    .resp_valid_o (acc_resp_valid)
  );

endmodule

`default_nettype wire

// ==== design/fall_through_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module fall_through_reg import core_if_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     clr_i,
  input  logic     valid_i,
  input  fu_data_t data_i,
  output logic     ready_o,
  output logic     valid_o,
  output fu_data_t data_o,
  input  logic     ready_i
);

  logic     full_q;
  fu_data_t data_q;
  logic     load;

  // Empty: input goes straight through
  // Full: the caught entry is shown until taken
  assign valid_o = full_q | valid_i;
  assign data_o  = full_q ? data_q : data_i;

  // Room when empty, or when the caught entry leaves this cycle
  assign ready_o = ~full_q | ready_i;

  // Catch the input when it cannot pass this cycle
  // That is when we are empty with a stalled output, or full and draining
  assign load = valid_i & ready_o & (full_q | ~ready_i);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clr_i) begin
      full_q <= 1'b0;
    end else if (!full_q || ready_i) begin
      full_q <= load;
    end
  end

  // Payload only, no reset needed
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/stream_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_reg import core_if_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     clr_i,
  input  logic     valid_i,
  input  fu_data_t data_i,
  output logic     ready_o,
  output logic     valid_o,
  output fu_data_t data_o,
  input  logic     ready_i
);

  logic     valid_q;
  fu_data_t data_q;

  // Accept when empty or when the held entry is taken this cycle
  assign ready_o = ~valid_q | ready_i;

  assign valid_o = valid_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || clr_i) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Data follows the valid bit, no reset
  always_ff @(posedge clk_i) begin
    if (ready_o && valid_i) begin
      data_q <= data_i;
    end
  end

endmodule

`default_nettype wire

// ==== dv/acc_subsys_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module acc_subsys_tb import core_if_pkg::*; import acc_if_pkg::*; ();

  localparam int unsigned ACC_LATENCY = 3;
  // Total operations issued over all scenarios
  localparam int NUM_OPS = 45;
  localparam int MAX_OPS = 64;
  // 200 cycles per operation plus margin, 10 ns each
  localparam int WATCHDOG_NS = (NUM_OPS * 200 + 500) * 10;

  typedef struct packed {
    logic                error;
    logic [XLEN-1:0]     result;
  } pred_t;

  // One operation waiting to be offered on the issue port
  typedef struct packed {
    fu_data_t            data;
    int                  seq;
    logic [2:0]          delay;
    logic                auto_commit;
    logic                exp_resp;
  } op_desc_t;

  typedef struct packed {
    int                  seq;
    trans_id_t           id;
    logic [2:0]          delay;
  } commit_ent_t;

  typedef struct packed {
    int                  seq;
    trans_id_t           id;
    logic                error;
    logic [XLEN-1:0]     result;
  } exp_ent_t;

  logic            clk_i                 = 1'b0;
  logic            rst_n_i               = 1'b0;
  logic            flush_i               = 1'b0;
  logic            acc_cons_en_i         = 1'b0;
  fu_data_t        acc_data_i            = '0;
  logic            acc_valid_i           = 1'b0;
  logic            acc_ready_o;
  logic            acc_commit_i          = 1'b0;
  trans_id_t       acc_commit_trans_id_i = '0;
  logic            acc_no_st_pending_i   = 1'b1;
  logic            acc_ld_disp_o;
  logic            acc_st_disp_o;
  logic            acc_flush_undisp_o;
  trans_id_t       acc_trans_id_o;
  logic [XLEN-1:0] acc_result_o;
  logic            acc_valid_o;
  exception_t      acc_exception_o;

  op_desc_t        issue_q  [$];
  commit_ent_t     commit_q [$];
  exp_ent_t        exp_q    [$];
  bit              commit_seen [MAX_OPS];
  op_desc_t        cur_op;
  logic            offering     = 1'b0;
  logic            commit_armed = 1'b0;
  logic [2:0]      commit_wait  = 3'd0;
  logic            stall_active = 1'b0;
  trans_id_t       next_id  = '0;
  int              next_seq = 0;
  int              n_checked = 0;
  int              val_errs  = 0;
  int              seq_errs  = 0;
  int              ctl_errs  = 0;

  // 10 ns clock
  always #5 clk_i = ~clk_i;

  acc_subsys_top #(
    .ACC_LATENCY (ACC_LATENCY)
  ) i_dut (
    .clk_i                 (clk_i),
    .rst_n_i               (rst_n_i),
    .flush_i               (flush_i),
    .acc_cons_en_i         (acc_cons_en_i),
    .acc_data_i            (acc_data_i),
    .acc_valid_i           (acc_valid_i),
    .acc_ready_o           (acc_ready_o),
    .acc_commit_i          (acc_commit_i),
    .acc_commit_trans_id_i (acc_commit_trans_id_i),
    .acc_no_st_pending_i   (acc_no_st_pending_i),
    .acc_ld_disp_o         (acc_ld_disp_o),
    .acc_st_disp_o         (acc_st_disp_o),
    .acc_flush_undisp_o    (acc_flush_undisp_o),
    .acc_trans_id_o        (acc_trans_id_o),
    .acc_result_o          (acc_result_o),
    .acc_valid_o           (acc_valid_o),
    .acc_exception_o       (acc_exception_o)
  );

  // Expected outcome of one custom instruction
  function automatic pred_t predict(input logic [31:0] insn, input logic [XLEN-1:0] a,
                                    input logic [XLEN-1:0] b);
    pred_t           p;
    logic [XLEN-1:0] imm;
    imm      = {{(XLEN-12){insn[31]}}, insn[31:20]};
    p.error  = 1'b0;
    p.result = '0;
    if (insn[6:0] != ACC_OPCODE) begin
      p.error = 1'b1;
    end else begin
      case (insn[14:12])
        F_ADD:   p.result = a + b;
        F_SUB:   p.result = a - b;
        F_XOR:   p.result = a ^ b;
        F_ADDI:  p.result = a + imm;
        default: p.error = 1'b1;
      endcase
    end
    return p;
  endfunction

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // Queue one operation with random operands and register fields
  task automatic push_op(input fu_op_e op, input logic [2:0] funct, input logic [6:0] opc,
                         input bit neg_imm, input bit auto_c, input bit exp_r);
    op_desc_t d;
    d.data.operator  = op;
    d.data.operand_a = $urandom();
    d.data.operand_b = $urandom();
    d.data.imm       = $urandom();
    d.data.imm[14:12] = funct;
    d.data.imm[6:0]  = opc;
    if (neg_imm) begin
      d.data.imm[31] = 1'b1;
    end
    d.data.trans_id  = next_id;
    d.seq            = next_seq;
    d.delay          = 3'($urandom() % 5);
    d.auto_commit    = auto_c;
    d.exp_resp       = exp_r;
    issue_q.push_back(d);
    next_id  = next_id + 1'b1;
    next_seq = next_seq + 1;
  endtask

  // Commit for the most recently queued operation
  task automatic commit_last();
    commit_ent_t c;
    c.seq   = next_seq - 1;
    c.id    = next_id - 1'b1;
    c.delay = 3'd0;
    commit_q.push_back(c);
  endtask

  task automatic wait_accepted();
    while (issue_q.size() != 0 || offering) begin
      next_cycle();
    end
  endtask

  task automatic wait_drain(input int limit);
    int cycles;
    cycles = 0;
    while ((issue_q.size() != 0 || offering || commit_q.size() != 0 || exp_q.size() != 0)
           && cycles < limit) begin
      next_cycle();
      cycles++;
    end
    if (issue_q.size() != 0 || offering || commit_q.size() != 0 || exp_q.size() != 0) begin
      ctl_errs++;
      $display("Operations still outstanding after %0d cycles at %0d ns", limit, $time);
    end
  endtask

  task automatic check_disp(input fu_op_e op);
    if (acc_ld_disp_o !== (op == ACCEL_OP_LOAD)) begin
      ctl_errs++;
      $display("** Error @ %0d ns: acc_ld_disp_o is %b for operator %s",
               $time, acc_ld_disp_o, op.name());
    end
    if (acc_st_disp_o !== (op == ACCEL_OP_STORE)) begin
      ctl_errs++;
      $display("** Error @ %0d ns: acc_st_disp_o is %b for operator %s",
               $time, acc_st_disp_o, op.name());
    end
  endtask

  // Issue and commit driver
  // Offers are made only after ready was seen high, commits follow offers in order
  always @(posedge clk_i) begin : drive_ops
    exp_ent_t    e;
    pred_t       p;
    commit_ent_t c;
    if (rst_n_i) begin
      if (offering && acc_ready_o) begin
        // Taken at this edge
        if (cur_op.exp_resp) begin
          p = predict(cur_op.data.imm, cur_op.data.operand_a, cur_op.data.operand_b);
          e.seq    = cur_op.seq;
          e.id     = cur_op.data.trans_id;
          e.error  = p.error;
          e.result = p.result;
          exp_q.push_back(e);
        end
        offering = 1'b0;
        acc_valid_i <= 1'b0;
      end else if (!offering && acc_ready_o && issue_q.size() != 0) begin
        cur_op   = issue_q.pop_front();
        offering = 1'b1;
        acc_valid_i <= 1'b1;
        acc_data_i  <= cur_op.data;
        if (cur_op.auto_commit) begin
          c.seq   = cur_op.seq;
          c.id    = cur_op.data.trans_id;
          c.delay = cur_op.delay;
          commit_q.push_back(c);
        end
      end
      acc_commit_i <= 1'b0;
      if (!commit_armed && commit_q.size() != 0) begin
        commit_armed = 1'b1;
        commit_wait  = commit_q[0].delay;
      end
      if (commit_armed) begin
        if (commit_wait == 3'd0) begin
          c = commit_q.pop_front();
          acc_commit_i          <= 1'b1;
          acc_commit_trans_id_i <= c.id;
          commit_seen[c.seq]    = 1'b1;
          commit_armed          = 1'b0;
        end else begin
          commit_wait = commit_wait - 3'd1;
        end
      end
    end
  end

  // Response checker, samples mid-cycle
  always @(negedge clk_i) begin : check_resp
    exp_ent_t e;
    if (rst_n_i) begin
      if (acc_flush_undisp_o !== flush_i) begin
        val_errs++;
        $display("** Error @ %0d ns: acc_flush_undisp_o does not follow flush_i", $time);
      end
      if (acc_valid_o) begin
        if (stall_active) begin
          seq_errs++;
          $display("** Error @ %0d ns: response id %0d while a store is pending",
                   $time, acc_trans_id_o);
        end
        if (exp_q.size() == 0) begin
          seq_errs++;
          $display("** Error @ %0d ns: response id %0d with nothing outstanding",
                   $time, acc_trans_id_o);
        end else begin
          e = exp_q.pop_front();
          n_checked++;
          if (!commit_seen[e.seq]) begin
            seq_errs++;
            $display("** Error @ %0d ns: id %0d answered before its commit", $time, e.id);
          end
          if (acc_trans_id_o !== e.id) begin
            val_errs++;
            $display("** Error @ %0d ns: trans id %0d, expected %0d", $time, acc_trans_id_o, e.id);
          end
          if (acc_result_o !== e.result) begin
            val_errs++;
            $display("** Error @ %0d ns: id %0d result %h, expected %h",
                     $time, e.id, acc_result_o, e.result);
          end
          if (acc_exception_o.valid !== e.error) begin
            val_errs++;
            $display("** Error @ %0d ns: id %0d exception valid %b, expected %b",
                     $time, e.id, acc_exception_o.valid, e.error);
          end
          if (e.error && (acc_exception_o.cause !== CAUSE_ILLEGAL_INSTR ||
                          acc_exception_o.tval !== '0)) begin
            val_errs++;
            $display("** Error @ %0d ns: id %0d exception cause %0d tval %h",
                     $time, e.id, acc_exception_o.cause, acc_exception_o.tval);
          end
        end
      end
    end
  end

  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired at %0d ns, the run did not finish", $time);
    $display("test failed");
    $finish;
  end

  initial begin : main_seq
    int unsigned seed;
    int          cycles;
    seed = $urandom(27231);
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    next_cycle();
    if (acc_ready_o !== 1'b1 || acc_valid_o !== 1'b0 || acc_ld_disp_o !== 1'b0 ||
        acc_st_disp_o !== 1'b0) begin
      ctl_errs++;
      $display("** Error @ %0d ns: outputs not idle after reset", $time);
    end

    // Legal operations, early and late commits
    for (int i = 0; i < 24; i++) begin
      push_op(ACCEL_OP, 3'(i % 4), ACC_OPCODE, (i % 8) == 3, 1'b1, 1'b1);
    end
    wait_drain(400);

    // Wrong major opcode and undefined funct3
    push_op(ACCEL_OP, F_ADD, 7'b0110011, 1'b0, 1'b1, 1'b1);
    push_op(ACCEL_OP, F_ADDI, 7'b0101011, 1'b0, 1'b1, 1'b1);
    push_op(ACCEL_OP, 3'd4, ACC_OPCODE, 1'b0, 1'b1, 1'b1);
    push_op(ACCEL_OP, 3'd7, ACC_OPCODE, 1'b0, 1'b1, 1'b1);
    wait_drain(100);

    // Flush an uncommitted head twice
    repeat (2) begin
      push_op(ACCEL_OP, F_XOR, ACC_OPCODE, 1'b0, 1'b0, 1'b0);
      wait_accepted();
      repeat (3) next_cycle();
      @(posedge clk_i);
      flush_i <= 1'b1;
      @(posedge clk_i);
      flush_i <= 1'b0;
      repeat (ACC_LATENCY + 4) next_cycle();
    end
    for (int i = 0; i < 4; i++) begin
      push_op(ACCEL_OP, 3'(i % 4), ACC_OPCODE, 1'b1, 1'b1, 1'b1);
    end
    wait_drain(100);

    // Pending store with consistency mode on stalls the request
    @(posedge clk_i);
    acc_cons_en_i       <= 1'b1;
    acc_no_st_pending_i <= 1'b0;
    #1 stall_active = 1'b1;
    for (int i = 0; i < 4; i++) begin
      push_op(ACCEL_OP, 3'(i % 4), ACC_OPCODE, 1'b0, 1'b1, 1'b1);
    end
    cycles = 0;
    while (acc_ready_o && cycles < 50) begin
      next_cycle();
      cycles++;
    end
    // Head and fall-through register each hold one operation once ready drops
    if (acc_ready_o) begin
      ctl_errs++;
      $display("acc_ready_o never dropped while a store was pending");
    end else if (issue_q.size() != 2 || offering) begin
      ctl_errs++;
      $display("acc_ready_o dropped with %0d operations still waiting instead of 2",
               issue_q.size() + offering);
    end
    repeat (10) next_cycle();
    @(posedge clk_i);
    acc_no_st_pending_i <= 1'b1;
    #1 stall_active = 1'b0;
    wait_drain(100);

    // Same pending store, consistency mode off
    @(posedge clk_i);
    acc_cons_en_i       <= 1'b0;
    acc_no_st_pending_i <= 1'b0;
    for (int i = 0; i < 4; i++) begin
      push_op(ACCEL_OP, 3'(i % 4), ACC_OPCODE, 1'b0, 1'b1, 1'b1);
    end
    wait_drain(60);
    @(posedge clk_i);
    acc_no_st_pending_i <= 1'b1;

    // Dispatch strobes while each operator waits at the head
    for (int k = 0; k < 3; k++) begin
      fu_op_e op;
      op = (k == 0) ? ACCEL_OP_LOAD : (k == 1) ? ACCEL_OP_STORE : ACCEL_OP;
      push_op(op, F_ADD, ACC_OPCODE, 1'b0, 1'b0, 1'b1);
      wait_accepted();
      repeat (2) next_cycle();
      check_disp(op);
      commit_last();
      wait_drain(60);
    end

    repeat (ACC_LATENCY + 4) next_cycle();
    $display("Responses checked: %0d, value errors: %0d, order errors: %0d, control errors: %0d",
             n_checked, val_errs, seq_errs, ctl_errs);
    if (val_errs + seq_errs + ctl_errs == 0 && next_seq == NUM_OPS) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Builds the accelerator subsystem testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=acc_subsys_sim

verilator --binary --timing -f sim.f --top-module acc_subsys_tb -o "$BIN"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  echo "Simulation reported a failure, see $LOG"
  exit 1
fi

if ! grep -q "test passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi

exit 0

// ==== sim.f ====
common/core_if_pkg.sv
common/acc_if_pkg.sv
design/fall_through_reg.sv
design/stream_reg.sv
acc_dispatcher/acc_dispatcher.sv
accel/accel_alu.sv
design/acc_subsys_top.sv
dv/acc_subsys_tb.sv
